/* Makefile */
VERILATOR ?= verilator
TOP       ?= tinker_tb
RTL_TOP   ?= tinker_core
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/program_trace.txt */
# kind addr data: I = instruction word, D = initial 64-bit data, S = expected store in order
# integer ops, each result stored
I 00002000 90400200
I 00002004 908000f0
I 00002008 90c0003c
I 0000200c c1043000
I 00002010 98404000
I 00002014 d1443000
I 00002018 98405008
I 0000201c 01843000
I 00002020 98406010
I 00002024 09843000
I 00002028 98406018
I 0000202c 11843000
I 00002030 98406020
I 00002034 19840000
I 00002038 98406028
I 0000203c 91c00004
I 00002040 21847000
I 00002044 98406030
I 00002048 31847000
I 0000204c 98406038
# back-to-back chain on r6
I 00002050 89840000
I 00002054 98406040
I 00002058 c9800010
I 0000205c 98406048
I 00002060 d9800001
I 00002064 98406050
I 00002068 29800004
I 0000206c 98406058
I 00002070 39800008
I 00002074 98406060
I 00002078 1b800000
I 0000207c 899c0000
I 00002080 91800123
I 00002084 98406068
# load then immediate use
I 00002088 92000300
I 0000208c 82500000
I 00002090 ca400001
I 00002094 98409070
# branch targets and branches, 98400f00 is a store that must never happen
I 00002098 92800008
I 0000209c 92c00001
I 000020a0 3ac0000d
I 000020a4 cac000e0
I 000020a8 8b160000
I 000020ac cb00000c
I 000020b0 8b580000
I 000020b4 cb400014
I 000020b8 5b000000
I 000020bc 9840a078
I 000020c0 50000002
I 000020c4 98400f00
I 000020c8 98407080
I 000020cc 4a800000
I 000020d0 98400f00
I 000020d4 98403088
I 000020d8 42c00000
I 000020dc 98400f00
I 000020e0 98402090
I 000020e4 5b1c0000
I 000020e8 98400f00
I 000020ec 98405098
I 000020f0 73402000
I 000020f4 984040a0
I 000020f8 7340e000
I 000020fc 98400f00
I 00002100 984010a8
I 00002104 78000000
I 00002108 98400f00
D 00000300 0000000012345678
S 00000200 000000000000012c
S 00000208 00000000000000b4
S 00000210 0000000000000030
S 00000218 00000000000000fc
S 00000220 00000000000000cc
S 00000228 ffffffffffffff0f
S 00000230 000000000000000f
S 00000238 0000000000000f00
S 00000240 00000000000000f0
S 00000248 0000000000000100
S 00000250 00000000000000ff
S 00000258 000000000000000f
S 00000260 0000000000000f00
S 00000268 fffffffffffff123
S 00000270 0000000012345679
S 00000278 0000000000000008
S 00000280 0000000000000004
S 00000288 000000000000003c
S 00000290 00000000000000f0
S 00000298 00000000000000b4
S 000002a0 000000000000012c
S 000002a8 0000000000000200

/* dv/tinker_asserts.sv */
module tinker_asserts import tinker_pkg::*; (
    input logic      clk,
    input logic      reset,
    input dmem_req_t dmem_req,
    input logic      hlt
);

    // sticky until reset
    hlt_stays_high: assert property (
        @(posedge clk) disable iff (reset) hlt |=> hlt
    ) else $error("hlt dropped without reset");

    // data port does one thing per cycle
    no_read_and_write: assert property (
        @(posedge clk) disable iff (reset) !(dmem_req.read && dmem_req.write)
    ) else $error("dmem read and write high together");

    no_store_after_halt: assert property (
        @(posedge clk) disable iff (reset) hlt |-> !dmem_req.write
    ) else $error("store strobe while hlt is high");

endmodule

bind tinker_core tinker_asserts u_asserts (
    .clk     (clk),
    .reset   (reset),
    .dmem_req(dmem_req),
    .hlt     (hlt)
);

/* dv/tinker_tb.sv */
module tinker_tb import tinker_pkg::*; ();

    localparam string TRACE_FILE = "dv/program_trace.txt";

    logic      clk;
    logic      reset;
    addr_t     imem_addr;
    instr_t    imem_data;
    dmem_req_t dmem_req;
    word_t     dmem_rdata;
    logic      hlt;

    logic [7:0] mem [addr_t];  // sparse byte memory, code and data
    addr_t      exp_addr [$];  // expected stores, in order
    word_t      exp_data [$];

    int   mismatches;
    int   other_errors;
    int   trace_lines;
    int   store_count;
    logic hlt_latched;   // hlt has been seen high
    logic trace_loaded;

    tinker_core #(
        .pc_reset_addr(32'h2000)
    ) DUT (
        .clk       (clk),
        .reset     (reset),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .dmem_req  (dmem_req),
        .dmem_rdata(dmem_rdata),
        .hlt       (hlt)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [7:0] read_byte(addr_t a);
        return mem.exists(a) ? mem[a] : 8'h00;  // unwritten bytes read as zero
    endfunction

    // little endian, 8 bytes
    function automatic word_t read_word(addr_t a);
        word_t w;
        for (int i = 0; i < 8; i++)
            w[8*i +: 8] = read_byte(addr_t'(a + i));
        return w;
    endfunction

    task automatic write_word(addr_t a, word_t w);
        for (int i = 0; i < 8; i++)
            mem[addr_t'(a + i)] = w[8*i +: 8];
    endtask

    // both ports answer in the same cycle, nop until the image is in
    always_comb imem_data = trace_loaded ? instr_t'(read_word(imem_addr)) : NOP_INSTR;
    always_comb dmem_rdata = dmem_req.read ? read_word(dmem_req.addr) : '0;

    task automatic compare_addr(string what, addr_t got, addr_t exp);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s got %h, expected %h", $time, what, got, exp);
            mismatches++;
        end
    endtask

    task automatic compare_word(string what, word_t got, word_t exp);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s got %h, expected %h", $time, what, got, exp);
            mismatches++;
        end
    endtask

    task automatic compare_bit(string what, logic got, logic exp);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s got %b, expected %b", $time, what, got, exp);
            mismatches++;
        end
    endtask

    // kinds: I instruction word, D initial data, S expected store
    task automatic load_trace();
        int    fd;
        int    code;
        byte   kind;
        addr_t a;
        word_t d;
        string rest;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("could not open the trace file %s", TRACE_FILE);
            other_errors++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", kind);
            if (code != 1)
                break;
            if (kind == "#") begin
                code = $fgets(rest, fd);  // comment line
                continue;
            end
            code = $fscanf(fd, " %h %h", a, d);
            if (code != 2) begin
                $display("trace line of kind %c could not be parsed", kind);
                other_errors++;
                break;
            end
            trace_lines++;
            case (kind)
                "I": for (int i = 0; i < 4; i++)
                         mem[addr_t'(a + i)] = d[8*i +: 8];
                "D": write_word(a, d);
                "S": begin
                    exp_addr.push_back(a);
                    exp_data.push_back(d);
                end
                default: begin
                    $display("trace line has an unknown kind %c", kind);
                    other_errors++;
                end
            endcase
        end
        $fclose(fd);
    endtask

    task automatic check_store(addr_t a, word_t d);
        store_count++;
        if (exp_addr.size() == 0) begin
            $display("store to %h with data %h at time %0t was not expected", a, d, $time);
            other_errors++;
        end else begin
            compare_addr("store address", a, exp_addr.pop_front());
            compare_word("store data", d, exp_data.pop_front());
        end
        write_word(a, d);  // store lands at this edge
    endtask

    // sampled at the edge, values are the ones held through the cycle
    always @(posedge clk) begin
        if (!reset) begin
            if (dmem_req.write)
                check_store(dmem_req.addr, dmem_req.wdata);
            if (hlt_latched && hlt !== 1'b1) begin
                $display("hlt fell at time %0t after it had risen", $time);
                other_errors++;
            end
            if (hlt === 1'b1)
                hlt_latched <= 1'b1;
        end
    end

    initial begin
        reset        = 1'b1;
        mismatches   = 0;
        other_errors = 0;
        trace_lines  = 0;
        store_count  = 0;
        hlt_latched  = 1'b0;
        trace_loaded = 1'b0;
        load_trace();
        trace_loaded = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        compare_addr("first fetch address", imem_addr, 32'h2000);
        compare_bit("dmem read after reset", dmem_req.read, 1'b0);
        compare_bit("dmem write after reset", dmem_req.write, 1'b0);
        compare_bit("hlt after reset", hlt, 1'b0);
        wait (hlt === 1'b1);
        repeat (10) @(posedge clk);  // window for any stray store after halt
        if (exp_addr.size() != 0) begin
            $display("%0d listed stores never happened", exp_addr.size());
            other_errors++;
        end
        $display("errors: %0d mismatches, %0d other, %0d stores seen",
                 mismatches, other_errors, store_count);
        if (mismatches == 0 && other_errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    // budget of 40 cycles per trace line
    initial begin
        wait (trace_loaded);
        repeat ((trace_lines + 1) * 40) @(posedge clk);
        $display("watchdog expired after %0d cycles", (trace_lines + 1) * 40);
        if (!hlt_latched)
            $display("the core never raised hlt");
        if (exp_addr.size() != 0)
            $display("%0d listed stores never happened", exp_addr.size());
        $display("errors: %0d mismatches, %0d other, %0d stores seen",
                 mismatches, other_errors + 1, store_count);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* project.f */
source/tinker_pkg.sv
source/fetch_stage.sv
source/reg_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/mem_wb_stage.sv
source/tinker_core.sv
dv/tinker_asserts.sv
dv/tinker_tb.sv

/* source/decode_stage.sv */
module decode_stage import tinker_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  addr_t    ifid_pc,
    input  instr_t   ifid_instr,
    output reg_idx_t rd_idx,
    output reg_idx_t rs_idx,
    output reg_idx_t rt_idx,
    input  word_t    rd_val,
    input  word_t    rs_val,
    input  word_t    rt_val,
    output logic     stall,
    output logic     take_branch,
    output addr_t    branch_target,
    output logic     halt_seen,
    output idex_t    idex
);

    opcode_t  opcode;
    literal_t literal;
    ctrl_t    ctrl;
    logic     taken;   // branch condition before stall gating
    logic     use_hit;

    // fixed field positions
    assign opcode  = opcode_t'(ifid_instr[31:27]);
    assign rd_idx  = ifid_instr[26:22];
    assign rs_idx  = ifid_instr[21:17];
    assign rt_idx  = ifid_instr[16:12];
    assign literal = ifid_instr[11:0];

    // control bits per opcode
    always_comb begin
        ctrl = '0;
        case (opcode)
            op_add, op_addi, op_sub, op_subi,
            op_and, op_or, op_xor, op_not,
            op_shftr, op_shftri, op_shftl, op_shftli,
            op_nop_mov, op_mov_l:
                ctrl.reg_write = 1'b1;
            op_load: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            op_store: ctrl.mem_write = 1'b1;
            op_halt:  ctrl.halt      = 1'b1;
            default:  ctrl = '0;  // branches and unknowns carry nothing
        endcase
    end

    // early branch resolve, operands straight from the register file
    always_comb begin
        taken         = 1'b0;
        branch_target = rd_val[31:0];
        case (opcode)
            op_br:     taken = 1'b1;
            op_brr_rd: begin
                taken         = 1'b1;
                branch_target = ifid_pc + rd_val[31:0];
            end
            op_brr_l: begin
                taken         = 1'b1;
                branch_target = ifid_pc + {{18{literal[11]}}, literal, 2'b00};
            end
            op_brnz:   taken = (rs_val != '0);
            op_brgt:   taken = ($signed(rs_val) > $signed(rt_val));
            default:   taken = 1'b0;
        endcase
    end

    // load in ID/EX feeding any field read here, r0 excluded
    assign use_hit = idex.ctrl.mem_read && idex.rd != '0 &&
                     (idex.rd == rd_idx || idex.rd == rs_idx || idex.rd == rt_idx);
    assign stall       = use_hit;
    assign take_branch = taken && !stall;                  // redirect waits out the stall
    assign halt_seen   = (opcode == op_halt) && !stall;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            idex <= '0;
        end else if (stall || take_branch) begin
            idex <= '0;  // bubble
        end else begin
            idex.ctrl    <= ctrl;
            idex.opcode  <= opcode;
            idex.rd      <= rd_idx;
            idex.rs      <= rs_idx;
            idex.rt      <= rt_idx;
            idex.literal <= literal;
            idex.rd_val  <= rd_val;
            idex.rs_val  <= rs_val;
            idex.rt_val  <= rt_val;
        end
    end

endmodule

/* source/execute_stage.sv */
module execute_stage import tinker_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  idex_t  idex,
    input  wb_t    wb,
    output exmem_t exmem
);

    fwd_sel_t rd_sel, rs_sel, rt_sel;
    word_t    rd_op, rs_op, rt_op;  // operands after forwarding
    word_t    lit;                  // zero-extended literal
    word_t    alu_result;

    // newest producer wins, r0 never forwarded
    function automatic fwd_sel_t fwd_select(reg_idx_t src);
        if (exmem.ctrl.reg_write && exmem.dest != '0 && exmem.dest == src)
            return fwd_exmem;
        if (wb.write && wb.dest != '0 && wb.dest == src)
            return fwd_memwb;
        return fwd_rf;
    endfunction

    function automatic word_t fwd_value(fwd_sel_t sel, word_t rf_val);
        case (sel)
            fwd_exmem: return exmem.alu_result;
            fwd_memwb: return wb.data;
            default:   return rf_val;
        endcase
    endfunction

    always_comb begin
        rd_sel = fwd_select(idex.rd);
        rs_sel = fwd_select(idex.rs);
        rt_sel = fwd_select(idex.rt);
    end

    always_comb begin
        rd_op = fwd_value(rd_sel, idex.rd_val);
        rs_op = fwd_value(rs_sel, idex.rs_val);
        rt_op = fwd_value(rt_sel, idex.rt_val);
    end

    assign lit = {52'd0, idex.literal};

    // integer alu, shift counts from the low 6 bits
    always_comb begin
        case (idex.opcode)
            op_add:     alu_result = rs_op + rt_op;
            op_addi:    alu_result = rd_op + lit;
            op_sub:     alu_result = rs_op - rt_op;
            op_subi:    alu_result = rd_op - lit;
            op_and:     alu_result = rs_op & rt_op;
            op_or:      alu_result = rs_op | rt_op;
            op_xor:     alu_result = rs_op ^ rt_op;
            op_not:     alu_result = ~rs_op;
            op_shftr:   alu_result = rs_op >> rt_op[5:0];
            op_shftri:  alu_result = rd_op >> idex.literal[5:0];
            op_shftl:   alu_result = rs_op << rt_op[5:0];
            op_shftli:  alu_result = rd_op << idex.literal[5:0];
            op_nop_mov: alu_result = rs_op;
            op_mov_l:   alu_result = {rd_op[63:12], idex.literal};  // upper bits kept
            op_load:    alu_result = rs_op + lit;  // load address
            op_store:   alu_result = rd_op + lit;  // store address
            default:    alu_result = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            exmem <= '0;
        end else begin
            exmem.ctrl       <= idex.ctrl;
            exmem.alu_result <= alu_result;
            exmem.store_data <= rt_op;     // forwarded, so back-to-back stores work
            exmem.dest       <= idex.rd;
        end
    end

endmodule

/* source/fetch_stage.sv */
module fetch_stage import tinker_pkg::*; #(
    parameter addr_t pc_reset_addr = 32'h2000
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   stall,          // load-use hold
    input  logic   take_branch,
    input  addr_t  branch_target,
    input  logic   halt_seen,      // halt sitting in decode
    output addr_t  imem_addr,
    input  instr_t imem_data,
    output addr_t  ifid_pc,
    output instr_t ifid_instr
);

    core_state_t state;
    addr_t       pc;
    addr_t       pc_next;

    assign imem_addr = pc;  // instruction comes back same cycle

    // next pc: hold, target or sequential
    always_comb begin
        pc_next = pc + 32'd4;
        if (state == core_halted || stall || halt_seen)
            pc_next = pc;
        else if (take_branch)
            pc_next = branch_target;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= core_run;
            pc         <= pc_reset_addr;
            ifid_pc    <= pc_reset_addr;
            ifid_instr <= NOP_INSTR;
        end else begin
            pc <= pc_next;
            if (state == core_run && !stall) begin
                ifid_pc <= pc;
                if (halt_seen) begin
                    state      <= core_halted;  // fetch frozen until reset
                    ifid_instr <= NOP_INSTR;    // decode sees bubbles from here on
                end else if (take_branch)
                    ifid_instr <= NOP_INSTR;    // squash the word behind the branch
                else
                    ifid_instr <= imem_data;
            end
        end
    end

endmodule

/* source/mem_wb_stage.sv */
module mem_wb_stage import tinker_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  exmem_t    exmem,
    output dmem_req_t dmem_req,
    input  word_t     dmem_rdata,
    output wb_t       wb,
    output logic      hlt
);

    memwb_t memwb;
    logic   halt_flag;  // latches once halt retires

    // one-cycle strobes straight off EX/MEM
    always_comb begin
        dmem_req.read  = exmem.ctrl.mem_read;
        dmem_req.write = exmem.ctrl.mem_write;
        dmem_req.addr  = exmem.alu_result[31:0];
        dmem_req.wdata = exmem.store_data;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            memwb     <= '0;
            halt_flag <= 1'b0;
        end else begin
            memwb.ctrl       <= exmem.ctrl;
            memwb.load_data  <= dmem_rdata;  // valid only for loads
            memwb.alu_result <= exmem.alu_result;
            memwb.dest       <= exmem.dest;
            if (memwb.ctrl.halt)
                halt_flag <= 1'b1;
        end
    end

    // writeback select
    assign wb.write = memwb.ctrl.reg_write;
    assign wb.dest  = memwb.dest;
    assign wb.data  = memwb.ctrl.mem_to_reg ? memwb.load_data : memwb.alu_result;

    assign hlt = halt_flag | memwb.ctrl.halt;  // high as halt reaches writeback

endmodule

/* source/reg_file.sv */
module reg_file import tinker_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rd_idx,
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    output word_t    rd_val,
    output word_t    rs_val,
    output word_t    rt_val,
    input  wb_t      wb
);

    word_t regs [32];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 31; i++)
                regs[i] <= '0;
            regs[31] <= 64'h8_0000;  // stack pointer start
        end else if (wb.write) begin
            regs[wb.dest] <= wb.data;
        end
    end

    // same-cycle writeback shows through on every read port
    function automatic word_t read_port(reg_idx_t idx);
        if (wb.write && wb.dest == idx)
            return wb.data;
        return regs[idx];
    endfunction

    always_comb begin
        rd_val = read_port(rd_idx);
        rs_val = read_port(rs_idx);
        rt_val = read_port(rt_idx);
    end

endmodule

/* source/tinker_core.sv */
module tinker_core import tinker_pkg::*; #(
    parameter addr_t pc_reset_addr = 32'h2000
) (
    input  logic      clk,
    input  logic      reset,
    output addr_t     imem_addr,
    input  instr_t    imem_data,
    output dmem_req_t dmem_req,
    input  word_t     dmem_rdata,
    output logic      hlt
);

    // IF/ID
    addr_t  ifid_pc;
    instr_t ifid_instr;

    // decode back to fetch
    logic  stall;
    logic  take_branch;
    addr_t branch_target;
    logic  halt_seen;

    // register file ports
    reg_idx_t rd_idx, rs_idx, rt_idx;
    word_t    rd_val, rs_val, rt_val;

    // pipeline registers and the write channel
    idex_t  idex;
    exmem_t exmem;
    wb_t    wb;

    fetch_stage #(
        .pc_reset_addr(pc_reset_addr)
    ) u_fetch (
        .clk          (clk),
        .reset        (reset),
        .stall        (stall),
        .take_branch  (take_branch),
        .branch_target(branch_target),
        .halt_seen    (halt_seen),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .ifid_pc      (ifid_pc),
        .ifid_instr   (ifid_instr)
    );

    reg_file u_regs (
        .clk   (clk),
        .reset (reset),
        .rd_idx(rd_idx),
        .rs_idx(rs_idx),
        .rt_idx(rt_idx),
        .rd_val(rd_val),
        .rs_val(rs_val),
        .rt_val(rt_val),
        .wb    (wb)       // written at the writeback destination
    );

    decode_stage u_decode (
        .clk          (clk),
        .reset        (reset),
        .ifid_pc      (ifid_pc),
        .ifid_instr   (ifid_instr),
        .rd_idx       (rd_idx),
        .rs_idx       (rs_idx),
        .rt_idx       (rt_idx),
        .rd_val       (rd_val),
        .rs_val       (rs_val),
        .rt_val       (rt_val),
        .stall        (stall),
        .take_branch  (take_branch),
        .branch_target(branch_target),
        .halt_seen    (halt_seen),
        .idex         (idex)
    );

    execute_stage u_execute (
        .clk  (clk),
        .reset(reset),
        .idex (idex),
        .wb   (wb),      // MEM/WB forwarding source
        .exmem(exmem)
    );

    mem_wb_stage u_mem_wb (
        .clk       (clk),
        .reset     (reset),
        .exmem     (exmem),
        .dmem_req  (dmem_req),
        .dmem_rdata(dmem_rdata),
        .wb        (wb),
        .hlt       (hlt)
    );

endmodule

/* source/tinker_pkg.sv */
package tinker_pkg;

    typedef logic [63:0] word_t;     // register / data value
    typedef logic [31:0] addr_t;     // byte address
    typedef logic [31:0] instr_t;    // raw instruction word
    typedef logic [4:0]  reg_idx_t;  // register number
    typedef logic [11:0] literal_t;  // L field

    // kept opcodes only, anything else decodes as a bubble
    typedef enum logic [4:0] {
        op_and     = 5'h00,
        op_or      = 5'h01,
        op_xor     = 5'h02,
        op_not     = 5'h03,
        op_shftr   = 5'h04,
        op_shftri  = 5'h05,
        op_shftl   = 5'h06,
        op_shftli  = 5'h07,
        op_br      = 5'h08,  // pc = rd
        op_brr_rd  = 5'h09,  // pc += rd
        op_brr_l   = 5'h0a,  // pc += sext(L) << 2
        op_brnz    = 5'h0b,  // rs != 0 -> pc = rd
        op_brgt    = 5'h0e,  // rs > rt signed -> pc = rd
        op_halt    = 5'h0f,
        op_load    = 5'h10,  // rd = mem[rs + L]
        op_nop_mov = 5'h11,  // mov rd, rs
        op_mov_l   = 5'h12,  // rd[11:0] = L
        op_store   = 5'h13,  // mem[rd + L] = rt
        op_add     = 5'h18,
        op_addi    = 5'h19,
        op_sub     = 5'h1a,
        op_subi    = 5'h1b
    } opcode_t;

    typedef enum logic [1:0] {
        fwd_rf,     // value read in decode
        fwd_exmem,  // alu result one ahead
        fwd_memwb   // writeback value two ahead
    } fwd_sel_t;

    // fetch side run state
    typedef enum logic {
        core_run,
        core_halted
    } core_state_t;

    typedef struct packed {
        logic reg_write;
        logic mem_read;
        logic mem_write;
        logic mem_to_reg;
        logic halt;
    } ctrl_t;

    typedef struct packed {
        ctrl_t    ctrl;
        opcode_t  opcode;
        reg_idx_t rd;
        reg_idx_t rs;
        reg_idx_t rt;
        literal_t literal;
        word_t    rd_val;
        word_t    rs_val;
        word_t    rt_val;
    } idex_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    alu_result;  // also the data address
        word_t    store_data;
        reg_idx_t dest;
    } exmem_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    load_data;
        word_t    alu_result;
        reg_idx_t dest;
    } memwb_t;

    typedef struct packed {
        logic     write;
        reg_idx_t dest;
        word_t    data;
    } wb_t;

    typedef struct packed {
        logic  read;
        logic  write;
        addr_t addr;
        word_t wdata;
    } dmem_req_t;

    localparam instr_t NOP_INSTR = 32'h8800_0000;  // mov r0, r0

endpackage
